// File: verilog/ula_defines.svh
`ifndef ULA_DEFINES_SVH
`define ULA_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Frame timing, 48K
//////////////////////////////////////////////////////////////////////

// Cycles per line
`define HTOTAL 9'd448
// Lines per frame
`define VTOTAL 9'd312
// Visible paper window
`define PAPERW 9'd256
`define PAPERH 9'd192
// First column of horizontal sync
`define HSYNCBEG 9'd344
// First vsync line, flash counter ticks here too
`define VSYNCBEG 9'd248
// Interrupt width in clk7 cycles
`define INTLEN 9'd32
// Fetch column to displayed pixel
`define PIXLAT 9'd14

//////////////////////////////////////////////////////////////////////
// Ports and colour levels
//////////////////////////////////////////////////////////////////////

// ULAplus register select and data
`define ULAPLUSADDR 16'hBF3B
`define ULAPLUSDATA 16'hFF3B

// Per-channel output levels
`define CLVNONE 3'd0
`define CLVHALF 3'd5
`define CLVFULL 3'd7

`endif

// File: verilog/ulaPkg.sv
package ulaPkg;

   // Beam position, column then line
   typedef struct packed {
      logic [8:0] hc;
      logic [8:0] vc;
   } beamPos_t;

   // Strobes from fetch sequencer to serializer
   typedef struct packed {
      logic bitmapLoad;
      logic attrLoad;
      logic serialLoad;
      logic attrOutLoad;
      logic videoEnable;
   } fetchCtl_t;

   // Attribute byte, also ULAplus palette select in bits 7:6
   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrByte_t;

   // One pixel with its attribute
   typedef struct packed {
      logic      pixel;
      attrByte_t attr;
   } pixelOut_t;

   // Palette RAM write port
   typedef struct packed {
      logic       en;
      logic [5:0] index;
      logic [7:0] value;
   } palWrite_t;

   // Z80 I/O side, strobes active low
   typedef struct packed {
      logic [15:0] addr;
      logic        iorqN;
      logic        rdN;
      logic        wrN;
      logic [7:0]  data;
   } cpuBus_t;

   // 9-bit GRB output
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgb9_t;

endpackage

// File: verilog/beamCounter.sv
`timescale 1ns/1ps
`include "ula_defines.svh"

module beamCounter import ulaPkg::*; (
   input  logic     clk7,
   input  logic     rst_n,
   output beamPos_t beam,
   output logic     hsyncN,
   output logic     vsyncN,
   output logic     intN,
   output logic     flashPhase
);

   localparam logic [8:0] HSyncLen   = 9'd32;
   localparam logic [8:0] VSyncLines = 9'd4;

   logic       lineEnd;
   logic       frameEnd;
   logic [4:0] flashCnt;

   assign lineEnd  = (beam.hc == `HTOTAL - 9'd1);
   assign frameEnd = (beam.vc == `VTOTAL - 9'd1);

   // Column wraps every line, line wraps every frame
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         beam <= '0;
      end else if (lineEnd) begin
         beam.hc <= '0;
         beam.vc <= frameEnd ? 9'd0 : beam.vc + 9'd1;
      end else begin
         beam.hc <= beam.hc + 9'd1;
      end
   end

   // Sync windows, low active
   assign hsyncN = !((beam.hc >= `HSYNCBEG) && (beam.hc < `HSYNCBEG + HSyncLen));
   assign vsyncN = !((beam.vc >= `VSYNCBEG) && (beam.vc < `VSYNCBEG + VSyncLines));
   // Frame interrupt at start of the vsync line
   assign intN   = !((beam.vc == `VSYNCBEG) && (beam.hc < `INTLEN));

   // Once per frame, top bit toggles every 16 frames
   always_ff @(posedge clk7) begin
      if (!rst_n)
         flashCnt <= '0;
      else if ((beam.vc == `VSYNCBEG) && (beam.hc == 9'd0))
         flashCnt <= flashCnt + 5'd1;
   end
   assign flashPhase = flashCnt[4];

   hcInRange: assert property (@(posedge clk7) disable iff (!rst_n) beam.hc < `HTOTAL);

endmodule

// File: verilog/screenFetch.sv
`timescale 1ns/1ps
`include "ula_defines.svh"

module screenFetch import ulaPkg::*; (
   input  logic        clk7,
   input  logic        rst_n,
   input  beamPos_t    beam,
   output fetchCtl_t   ctl,
   output logic [13:0] va
);

   logic        paperFetch;
   logic [3:0]  phase;
   logic        attrAddr;
   logic [4:0]  colAddr;
   logic [13:0] bitmapVa;
   logic [13:0] attrVa;

   // Fetch window leads the display window by 8 columns
   assign paperFetch = (beam.hc < `PAPERW) && (beam.vc < `PAPERH);
   assign phase      = beam.hc[3:0];

   //////////////////////////////////////////////////////////////////////
   // Fetch phase decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      attrAddr = 1'b0;
      ctl      = '0;
      if (paperFetch) begin
         case (phase)
            // Bitmap address held while the second cycle latches
            4'd9, 4'd13: ctl.bitmapLoad = 1'b1;
            // Attribute address then latch
            4'd10, 4'd14: attrAddr = 1'b1;
            4'd11, 4'd15: begin
               attrAddr     = 1'b1;
               ctl.attrLoad = 1'b1;
            end
            default: attrAddr = 1'b0;
         endcase
      end
      // Display window covers columns 8..263 of a paper line
      ctl.videoEnable = (beam.hc >= 9'd8) && (beam.hc < `PAPERW + 9'd8) &&
                        (beam.vc < `PAPERH);
      ctl.serialLoad  = ctl.videoEnable && (beam.hc[2:0] == 3'd4);
      // Border attribute also moves on this beat
      ctl.attrOutLoad = (beam.hc[2:0] == 3'd4);
   end

   // Character column one step ahead of the fetch pair
   always_ff @(posedge clk7) begin
      if (!rst_n)
         colAddr <= '0;
      else if (beam.hc[2:0] == 3'd3)
         colAddr <= beam.hc[7:3];
   end

   // Interleaved bitmap order is third, pixel row, char row and column
   assign bitmapVa = {1'b0, beam.vc[7:6], beam.vc[2:0], beam.vc[5:3], colAddr};
   // Attribute block at 0x1800
   assign attrVa   = {1'b0, 3'b110, beam.vc[7:3], colAddr};
   assign va       = attrAddr ? attrVa : bitmapVa;

   loadExclusive: assert property (@(posedge clk7) disable iff (!rst_n)
      !(ctl.bitmapLoad && ctl.attrLoad));

endmodule

// File: verilog/pixelShifter.sv
`timescale 1ns/1ps

module pixelShifter import ulaPkg::*; (
   input  logic       clk7,
   input  logic       rst_n,
   input  fetchCtl_t  ctl,
   input  logic [7:0] vramData,
   input  logic [2:0] border,
   output pixelOut_t  pix
);

   logic [7:0] bitmapData;
   attrByte_t  attrData;
   logic [7:0] shiftReg;
   attrByte_t  attrLatch;
   attrByte_t  borderAttr;

   //////////////////////////////////////////////////////////////////////
   // VRAM holding registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (ctl.bitmapLoad)
         bitmapData <= vramData;
      if (ctl.attrLoad)
         attrData <= attrByte_t'(vramData);
   end

   //////////////////////////////////////////////////////////////////////
   // Serializer and attribute latch
   //////////////////////////////////////////////////////////////////////

   // MSB first, zeros shift in so border gets paper
   always_ff @(posedge clk7) begin
      if (!rst_n)
         shiftReg <= '0;
      else if (ctl.serialLoad)
         shiftReg <= bitmapData;
      else
         shiftReg <= {shiftReg[6:0], 1'b0};
   end

   // Border shows as paper colour, no bright or flash
   always_comb begin
      borderAttr        = '0;
      borderAttr.paper  = border;
   end

   // Same beat as the serializer load, so attr lines up with its byte
   always_ff @(posedge clk7) begin
      if (!rst_n)
         attrLatch <= '0;
      else if (ctl.attrOutLoad)
         attrLatch <= ctl.videoEnable ? attrData : borderAttr;
   end

   assign pix.pixel = shiftReg[7];
   assign pix.attr  = attrLatch;

endmodule

// File: verilog/colourMapper.sv
`timescale 1ns/1ps
`include "ula_defines.svh"

module colourMapper import ulaPkg::*; (
   input  logic       clk7,
   input  logic       rst_n,
   input  pixelOut_t  pix,
   input  logic       flashPhase,
   input  logic       plusEnable,
   input  palWrite_t  palWr,
   input  logic [5:0] paletteIndex,
   output logic [7:0] paletteReadback,
   output rgb9_t      rgb
);

   logic [7:0] palRam [64];
   logic       pixFlashed;
   logic [2:0] stdColour;
   logic [5:0] plusAddr;
   logic [7:0] plusEntry;
   rgb9_t      stdRgb;
   rgb9_t      plusRgb;

   // One GRB bit to a 3-bit level
   function automatic logic [2:0] level(input logic on, input logic bright);
      logic [2:0] lv;
      if (!on)
         lv = `CLVNONE;
      else if (bright)
         lv = `CLVFULL;
      else
         lv = `CLVHALF;
      return lv;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Standard palette
   //////////////////////////////////////////////////////////////////////

   // Flash swaps ink and paper
   assign pixFlashed = pix.pixel ^ (pix.attr.flash & flashPhase);
   assign stdColour  = pixFlashed ? pix.attr.ink : pix.attr.paper;

   // Colour bits are G R B
   assign stdRgb.g = level(stdColour[2], pix.attr.bright);
   assign stdRgb.r = level(stdColour[1], pix.attr.bright);
   assign stdRgb.b = level(stdColour[0], pix.attr.bright);

   //////////////////////////////////////////////////////////////////////
   // ULAplus palette
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (palWr.en)
         palRam[palWr.index] <= palWr.value;
   end

   // Flash and bright pick one of four 16-entry banks
   // Raw pixel here, bit 7 is a bank bit in this mode
   assign plusAddr = pix.pixel ?
                     {pix.attr.flash, pix.attr.bright, 1'b0, pix.attr.ink} :
                     {pix.attr.flash, pix.attr.bright, 1'b1, pix.attr.paper};
   assign plusEntry = palRam[plusAddr];

   // GGGRRRBB widened, blue low bit copies B1
   assign plusRgb.g = plusEntry[7:5];
   assign plusRgb.r = plusEntry[4:2];
   assign plusRgb.b = {plusEntry[1:0], plusEntry[1]};

   // CPU side read port
   assign paletteReadback = palRam[paletteIndex];

   // Output register
   always_ff @(posedge clk7) begin
      if (!rst_n)
         rgb <= '0;
      else
         rgb <= plusEnable ? plusRgb : stdRgb;
   end

endmodule

// File: verilog/cpuPorts.sv
`timescale 1ns/1ps
`include "ula_defines.svh"

module cpuPorts import ulaPkg::*; (
   input  logic       clk7,
   input  logic       rst_n,
   input  cpuBus_t    bus,
   output logic [7:0] dout,
   input  logic [4:0] kbd,
   input  logic       ear,
   output logic [2:0] border,
   output logic       mic,
   output logic       spk,
   output palWrite_t  palWr,
   output logic [5:0] paletteIndex,
   output logic       plusEnable,
   input  logic [7:0] paletteReadback
);

   localparam logic [2:0] BorderRed = 3'b010;

   logic       ioWr;
   logic       ioRd;
   logic       feSel;
   logic       plusAddrSel;
   logic       plusDataSel;
   logic [6:0] plusIndex;
   logic       plusConfig;

   // Level strobes without edge detect
   assign ioWr = !bus.iorqN && !bus.wrN;
   assign ioRd = !bus.iorqN && !bus.rdN;

   // Port FE answers any even address
   assign feSel       = !bus.addr[0];
   assign plusAddrSel = (bus.addr == `ULAPLUSADDR);
   assign plusDataSel = (bus.addr == `ULAPLUSDATA);

   //////////////////////////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= BorderRed;
         mic        <= 1'b0;
         spk        <= 1'b0;
         plusIndex  <= '0;
         plusConfig <= 1'b0;
      end else if (ioWr) begin
         // Border with MIC and speaker
         if (feSel) begin
            border <= bus.data[2:0];
            mic    <= bus.data[3];
            spk    <= bus.data[4];
         end
         if (plusAddrSel)
            plusIndex <= bus.data[6:0];
         // Index bit 6 selects the mode register
         if (plusDataSel && plusIndex[6])
            plusConfig <= bus.data[0];
      end
   end

   // Palette entry written in the strobe cycle
   assign palWr.en     = ioWr && plusDataSel && !plusIndex[6];
   assign palWr.index  = plusIndex[5:0];
   assign palWr.value  = bus.data;
   assign paletteIndex = plusIndex[5:0];
   assign plusEnable   = plusConfig;

   // Read mux returns FF on an idle bus
   always_comb begin
      dout = 8'hFF;
      if (ioRd) begin
         if (feSel)
            dout = {1'b1, ear ^ spk, 1'b1, kbd};
         else if (plusAddrSel)
            dout = {1'b0, plusIndex};
         else if (plusDataSel)
            dout = plusIndex[6] ? {7'b0, plusConfig} : paletteReadback;
      end
   end

endmodule

// File: verilog/ulaTop.sv
`timescale 1ns/1ps

module ulaTop import ulaPkg::*; (
   input  logic        clk7,
   input  logic        rst_n,
   input  cpuBus_t     bus,
   output logic [7:0]  dout,
   output logic [13:0] va,
   input  logic [7:0]  vramData,
   input  logic [4:0]  kbd,
   input  logic        ear,
   output logic        mic,
   output logic        spk,
   output rgb9_t       rgb,
   output logic        hsyncN,
   output logic        vsyncN,
   output logic        intN
);

   beamPos_t   beam;
   fetchCtl_t  ctl;
   pixelOut_t  pix;
   palWrite_t  palWr;
   logic       flashPhase;
   logic [2:0] border;
   logic [5:0] paletteIndex;
   logic       plusEnable;
   logic [7:0] paletteReadback;

   //////////////////////////////////////////////////////////////////////
   // Video pipeline
   //////////////////////////////////////////////////////////////////////

   beamCounter u_beam (
      .clk7(clk7), .rst_n(rst_n), .beam(beam), .hsyncN(hsyncN),
      .vsyncN(vsyncN), .intN(intN), .flashPhase(flashPhase)
   );

   screenFetch u_fetch (
      .clk7(clk7), .rst_n(rst_n), .beam(beam), .ctl(ctl), .va(va)
   );

   pixelShifter u_shift (
      .clk7(clk7), .rst_n(rst_n), .ctl(ctl), .vramData(vramData),
      .border(border), .pix(pix)
   );

   colourMapper u_colour (
      .clk7(clk7), .rst_n(rst_n), .pix(pix), .flashPhase(flashPhase),
      .plusEnable(plusEnable), .palWr(palWr), .paletteIndex(paletteIndex),
      .paletteReadback(paletteReadback), .rgb(rgb)
   );

   // CPU side registers
   cpuPorts u_ports (
      .clk7(clk7), .rst_n(rst_n), .bus(bus), .dout(dout), .kbd(kbd),
      .ear(ear), .border(border), .mic(mic), .spk(spk), .palWr(palWr),
      .paletteIndex(paletteIndex), .plusEnable(plusEnable),
      .paletteReadback(paletteReadback)
   );

endmodule

// File: bench/ulaTb.sv
`timescale 1ns/1ps
`include "ula_defines.svh"

module ulaTb import ulaPkg::*; ();

   // Longest run is the flash test at just over 16 frames
   localparam int TimeoutCycles = 20 * int'(`HTOTAL) * int'(`VTOTAL);

   logic        clk7 = 1'b0;
   logic        rst_n;
   cpuBus_t     bus;
   logic [7:0]  dout;
   logic [13:0] va;
   logic [7:0]  vramData;
   logic [4:0]  kbd;
   logic        ear;
   logic        mic;
   logic        spk;
   rgb9_t       rgb;
   logic        hsyncN;
   logic        vsyncN;
   logic        intN;

   logic [7:0]  vram [16384];
   logic [7:0]  palModel [64];
   logic [8:0]  tbHc;
   logic [8:0]  tbVc;
   logic [4:0]  flashCnt;
   int          cycleCount = 0;

   always #2 clk7 = ~clk7;

   // 16K screen memory answering without wait states
   assign vramData = vram[va];

   ulaTop u_dut (
      .clk7(clk7), .rst_n(rst_n), .bus(bus), .dout(dout), .va(va),
      .vramData(vramData), .kbd(kbd), .ear(ear), .mic(mic), .spk(spk),
      .rgb(rgb), .hsyncN(hsyncN), .vsyncN(vsyncN), .intN(intN)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference beam position and flash phase
   //////////////////////////////////////////////////////////////////////

   // Column 0 of line 0 in the first cycle after reset
   always @(posedge clk7) begin
      if (!rst_n) begin
         tbHc     <= '0;
         tbVc     <= '0;
         flashCnt <= '0;
      end else begin
         if (tbHc == `HTOTAL - 9'd1) begin
            tbHc <= '0;
            tbVc <= (tbVc == `VTOTAL - 9'd1) ? 9'd0 : tbVc + 9'd1;
         end else begin
            tbHc <= tbHc + 9'd1;
         end
         // One tick per frame at the vsync line
         if ((tbVc == `VSYNCBEG) && (tbHc == 9'd0))
            flashCnt <= flashCnt + 5'd1;
      end
   end

   // Run length guard
   always @(posedge clk7) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles) begin
         $display("Timeout: no result after %0d clock cycles", cycleCount);
         $display("=== FAIL ===");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   // Stop at the negedge of the next cycle at this beam position
   task automatic waitBeam(input logic [8:0] line, input logic [8:0] col);
      @(negedge clk7);
      while (!((tbVc == line) && (tbHc == col)))
         @(negedge clk7);
   endtask

   // Write strobe held for one edge
   task automatic writePort(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk7);
      bus.addr  <= addr;
      bus.data  <= data;
      bus.iorqN <= 1'b0;
      bus.wrN   <= 1'b0;
      @(posedge clk7);
      bus.iorqN <= 1'b1;
      bus.wrN   <= 1'b1;
   endtask

   task automatic readPort(input logic [15:0] addr, output logic [7:0] data);
      @(posedge clk7);
      bus.addr  <= addr;
      bus.iorqN <= 1'b0;
      bus.rdN   <= 1'b0;
      @(negedge clk7);
      data = dout;
      @(posedge clk7);
      bus.iorqN <= 1'b1;
      bus.rdN   <= 1'b1;
   endtask

   // GRB colour bits to channel levels
   function automatic rgb9_t levelColour(input logic [2:0] c, input logic bright);
      rgb9_t      res;
      logic [2:0] on;
      on    = bright ? `CLVFULL : `CLVHALF;
      res.g = c[2] ? on : `CLVNONE;
      res.r = c[1] ? on : `CLVNONE;
      res.b = c[0] ? on : `CLVNONE;
      return res;
   endfunction

   // Standard screen colour of paper pixel x on line y
   function automatic rgb9_t stdPixel(input logic [7:0] x, input logic [7:0] y,
                                      input logic phase);
      logic [13:0] bAddr;
      logic [13:0] aAddr;
      logic [7:0]  bits;
      logic [7:0]  attr;
      logic        ink;
      bAddr = {1'b0, y[7:6], y[2:0], y[5:3], x[7:3]};
      aAddr = 14'h1800 + {4'd0, y[7:3], x[7:3]};
      bits  = vram[bAddr];
      attr  = vram[aAddr];
      ink   = bits[3'd7 - x[2:0]] ^ (attr[7] & phase);
      return levelColour(ink ? attr[2:0] : attr[5:3], attr[6]);
   endfunction

   // ULAplus colour from the palette entry widened to 9 bits
   function automatic rgb9_t plusPixel(input logic [7:0] x, input logic [7:0] y);
      logic [13:0] bAddr;
      logic [13:0] aAddr;
      logic [7:0]  attr;
      logic [5:0]  idx;
      logic [7:0]  e;
      bAddr = {1'b0, y[7:6], y[2:0], y[5:3], x[7:3]};
      aAddr = 14'h1800 + {4'd0, y[7:3], x[7:3]};
      attr  = vram[aAddr];
      if (vram[bAddr][3'd7 - x[2:0]])
         idx = {attr[7:6], 1'b0, attr[2:0]};
      else
         idx = {attr[7:6], 1'b1, attr[5:3]};
      e = palModel[idx];
      return {e[7:5], e[4:2], e[1:0], e[1]};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic resetState();
      logic [7:0] d;
      @(negedge clk7);
      checkValue("reset intN", 32'(1'b1), 32'(intN));
      checkValue("reset hsyncN", 32'(1'b1), 32'(hsyncN));
      checkValue("reset vsyncN", 32'(1'b1), 32'(vsyncN));
      checkValue("reset spk", 32'(1'b0), 32'(spk));
      checkValue("reset mic", 32'(1'b0), 32'(mic));
      readPort(16'h00FE, d);
      checkValue("reset port FE", 32'({1'b1, ear, 1'b1, kbd}), 32'(d));
      // Border comes up red at half level
      waitBeam(9'd250, 9'd100);
      checkValue("reset border", 32'({`CLVNONE, `CLVHALF, `CLVNONE}), 32'(rgb));
   endtask

   task automatic paperPixels();
      int lines [10] = '{0, 1, 7, 8, 63, 64, 65, 127, 128, 191};
      foreach (lines[n]) begin
         waitBeam(9'(lines[n]), `PIXLAT);
         for (int x = 0; x < int'(`PAPERW); x++) begin
            if (x > 0)
               @(negedge clk7);
            checkValue($sformatf("paper y%0d x%0d", lines[n], x),
                       32'(stdPixel(8'(x), 8'(lines[n]), flashCnt[4])), 32'(rgb));
         end
      end
   endtask

   task automatic interruptPulse();
      waitBeam(`VSYNCBEG - 9'd1, `HTOTAL - 9'd1);
      checkValue("interrupt idle", 32'(1'b1), 32'(intN));
      for (int i = 0; i < int'(`INTLEN); i++) begin
         @(negedge clk7);
         checkValue($sformatf("interrupt low hc%0d", tbHc), 32'(1'b0), 32'(intN));
         if (i == 0)
            checkValue("vsync start", 32'(1'b0), 32'(vsyncN));
      end
      @(negedge clk7);
      checkValue("interrupt release", 32'(1'b1), 32'(intN));
      // Line sync pulse later on the same line
      waitBeam(`VSYNCBEG, `HSYNCBEG - 9'd1);
      checkValue("hsync idle", 32'(1'b1), 32'(hsyncN));
      for (int i = 0; i < 32; i++) begin
         @(negedge clk7);
         checkValue($sformatf("hsync low hc%0d", tbHc), 32'(1'b0), 32'(hsyncN));
      end
      @(negedge clk7);
      checkValue("hsync release", 32'(1'b1), 32'(hsyncN));
   endtask

   task automatic borderWrites();
      logic [7:0] d;
      logic [4:0] k;
      logic       s;
      logic       m;
      logic       e;
      for (int i = 0; i < 8; i++) begin
         s = i[0];
         m = i[1];
         e = i[2];
         k = 5'(i * 5);
         @(posedge clk7);
         ear <= e;
         kbd <= k;
         // Any even address reaches port FE
         writePort({5'(i), 11'h0FE}, {3'b000, s, m, 3'(i)});
         readPort(16'h00FE, d);
         checkValue("border EAR readback", 32'({1'b1, e ^ s, 1'b1, k}), 32'(d));
         checkValue("border spk", 32'(s), 32'(spk));
         checkValue("border mic", 32'(m), 32'(mic));
         waitBeam(tbVc + 9'd1, 9'd100);
         checkValue($sformatf("border colour %0d", i),
                    32'(levelColour(3'(i), 1'b0)), 32'(rgb));
      end
   endtask

   task automatic ulaplusPalette();
      logic [7:0] d;
      for (int i = 0; i < 64; i++) begin
         palModel[6'(i)] = 8'($urandom);
         writePort(`ULAPLUSADDR, 8'(i));
         writePort(`ULAPLUSDATA, palModel[6'(i)]);
      end
      for (int i = 0; i < 64; i++) begin
         writePort(`ULAPLUSADDR, 8'(i));
         readPort(`ULAPLUSDATA, d);
         checkValue($sformatf("palette entry %0d", i), 32'(palModel[6'(i)]), 32'(d));
      end
      // Index bit 6 reaches the mode register
      writePort(`ULAPLUSADDR, 8'h40);
      writePort(`ULAPLUSDATA, 8'h01);
      readPort(`ULAPLUSDATA, d);
      checkValue("ULAplus config on", 32'(8'h01), 32'(d));
      waitBeam(9'd100, `PIXLAT);
      for (int x = 0; x < int'(`PAPERW); x++) begin
         if (x > 0)
            @(negedge clk7);
         checkValue($sformatf("ULAplus y100 x%0d", x),
                    32'(plusPixel(8'(x), 8'd100)), 32'(rgb));
      end
      writePort(`ULAPLUSDATA, 8'h00);
      readPort(`ULAPLUSDATA, d);
      checkValue("ULAplus config off", 32'(8'h00), 32'(d));
   endtask

   task automatic flashSwap();
      // Four ink then four paper pixels at line 16 column 0 with flash set
      vram[14'h0040] = 8'hF0;
      vram[14'h1840] = 8'h8E;
      waitBeam(9'd16, `PIXLAT);
      for (int x = 0; x < 8; x++) begin
         if (x > 0)
            @(negedge clk7);
         checkValue($sformatf("flash before x%0d", x),
                    32'(stdPixel(8'(x), 8'd16, 1'b0)), 32'(rgb));
      end
      while (!flashCnt[4])
         @(negedge clk7);
      waitBeam(9'd16, `PIXLAT);
      for (int x = 0; x < 8; x++) begin
         if (x > 0)
            @(negedge clk7);
         checkValue($sformatf("flash after x%0d", x),
                    32'(stdPixel(8'(x), 8'd16, 1'b1)), 32'(rgb));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(17112));
      for (int i = 0; i < 16384; i++)
         vram[14'(i)] = 8'($urandom);
      rst_n <= 1'b0;
      bus   <= {16'hFFFF, 1'b1, 1'b1, 1'b1, 8'h00};
      kbd   <= 5'h15;
      ear   <= 1'b1;
      repeat (2) @(posedge clk7);
      rst_n <= 1'b1;
      resetState();
      paperPixels();
      interruptPulse();
      borderWrites();
      ulaplusPalette();
      flashSwap();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: files.f
+incdir+verilog
verilog/ulaPkg.sv
verilog/beamCounter.sv
verilog/screenFetch.sv
verilog/pixelShifter.sv
verilog/colourMapper.sv
verilog/cpuPorts.sv
verilog/ulaTop.sv
bench/ulaTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ULA testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module ulaTb -Mdir "$BUILD_DIR" -o ulaSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/ulaSim" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

echo "Simulation finished without failure"
exit 0
